// File: source/harness_pkg.sv
// Harness package with the bus width types and memory map constants
`default_nettype none

package harness_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;

  // Bytes per memory word, also the number of byte enables
  localparam int unsigned DataBytes = DataWidth / 8;

  // Byte address on the request bus
  typedef logic [AddrWidth-1:0] addr_t;

  // One memory word
  typedef logic [DataWidth-1:0] data_t;

  // One enable per byte of a word
  typedef logic [DataBytes-1:0] strb_t;

  // ----------------------------------------------------------------------
  // Memory map
  // ----------------------------------------------------------------------
  // Start of bank 0; the banks follow back to back
  localparam addr_t MemBase = 32'h8000_0000;

endpackage

`default_nettype wire

// File: source/reset_ctrl.sv
// Reset controller that synchronises the system reset and gates debug requests at boot
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl #(
  parameter int unsigned DebugDelayCycles = 16
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic sys_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CntW =
      (DebugDelayCycles > 0) ? $clog2(DebugDelayCycles + 1) : 1;

  logic            rst_comb_n;
  logic [1:0]      sync_q;
  logic [CntW-1:0] dbg_cnt_q;

  // ----------------------------------------------------------------------
  // System reset
  // ----------------------------------------------------------------------
  // Power-on reset or a debug module reset request
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Asserts at once, releases on the second edge
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  // ----------------------------------------------------------------------
  // Boot window
  // ----------------------------------------------------------------------
  // Loaded only by power-on reset, so ndmreset leaves the window alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_cnt_q <= CntW'(DebugDelayCycles);
    end else if (dbg_cnt_q != '0) begin
      dbg_cnt_q <= dbg_cnt_q - 1'b1;
    end
  end

  // Held off until the counter runs out
  assign debug_req_o = (dbg_cnt_q == '0) & debug_req_i & debug_en_i;

endmodule

`default_nettype wire

// File: source/bus_decoder.sv
// Bus decoder that maps request addresses onto the SRAM banks and tags the response
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
  parameter int unsigned NumBanks  = 4,
  parameter int unsigned BankWords = 64
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  harness_pkg::addr_t          addr_i,
  input  harness_pkg::strb_t          be_i,
  input  harness_pkg::data_t          wdata_i,
  output logic [NumBanks-1:0]         bank_req_o,
  output logic [$clog2(BankWords)-1:0] word_idx_o,
  output logic                        we_o,
  output harness_pkg::strb_t          be_o,
  output harness_pkg::data_t          wdata_o,
  output logic                        rsp_valid_o,
  output logic                        rsp_err_o,
  output logic [(NumBanks > 1 ? $clog2(NumBanks) : 1)-1:0] bank_sel_o
);

  localparam int unsigned IdxW     = $clog2(BankWords);
  localparam int unsigned OffW     = $clog2(harness_pkg::DataBytes);
  localparam int unsigned SelW     = (NumBanks > 1) ? $clog2(NumBanks) : 1;
  localparam int unsigned MapBytes = NumBanks * BankWords * harness_pkg::DataBytes;

  harness_pkg::addr_t offset;
  logic               in_map;
  logic [SelW-1:0]    bank_idx;

  logic               rsp_valid_q;
  logic               rsp_err_q;
  logic [SelW-1:0]    bank_sel_q;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  // Offset into the map, only meaningful when above the base
  assign offset   = addr_i - harness_pkg::MemBase;
  assign in_map   = (addr_i >= harness_pkg::MemBase) &&
                    (offset < harness_pkg::addr_t'(MapBytes));
  assign bank_idx = offset[OffW+IdxW +: SelW];

  // One-hot bank request
  // No requests are taken while the system reset is held
  always_comb begin
    bank_req_o = '0;
    if (req_i && rst_ni && in_map) begin
      bank_req_o[bank_idx] = 1'b1;
    end
  end

  // Shared by all banks, qualified by the bank request
  assign word_idx_o = addr_i[OffW +: IdxW];
  assign we_o       = we_i;
  assign be_o       = be_i;
  assign wdata_o    = wdata_i;

  // ----------------------------------------------------------------------
  // Response tag
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= req_i;
      rsp_err_q   <= req_i & ~in_map;
    end
  end

  // Bank select for the return mux
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      bank_sel_q <= bank_idx;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  assign bank_sel_o  = bank_sel_q;

endmodule

`default_nettype wire

// File: source/mem_bank.sv
// Memory bank holding one synchronous SRAM region with byte-enabled writes
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
  parameter int unsigned BankWords = 64
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(BankWords)-1:0] word_idx_i,
  input  harness_pkg::strb_t           be_i,
  input  harness_pkg::data_t           wdata_i,
  output harness_pkg::data_t           rdata_o
);

  harness_pkg::data_t mem_q [BankWords];
  harness_pkg::data_t rdata_q;

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < harness_pkg::DataBytes; b++) begin
        if (be_i[b]) begin
          mem_q[word_idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------
  // Old contents on a read, zero for a write response
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/resp_mux.sv
// Response mux that returns bank read data, zeroes errors and counts error responses
`timescale 1ns/1ps
`default_nettype none

module resp_mux #(
  parameter int unsigned NumBanks = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rsp_valid_i,
  input  logic                 rsp_err_i,
  input  logic [(NumBanks > 1 ? $clog2(NumBanks) : 1)-1:0] bank_sel_i,
  input  harness_pkg::data_t   bank_rdata_i [NumBanks],
  output logic                 rsp_valid_o,
  output logic                 rsp_err_o,
  output harness_pkg::data_t   rdata_o,
  output logic [7:0]           err_count_o
);

  logic [7:0] err_cnt_q;
  logic       err_rsp;

  // ----------------------------------------------------------------------
  // Return path
  // ----------------------------------------------------------------------
  assign rsp_valid_o = rsp_valid_i;
  assign rsp_err_o   = rsp_err_i;

  // Error responses carry no data, whatever the banks hold
  always_comb begin
    if (rsp_err_i) begin
      rdata_o = '0;
    end else begin
      rdata_o = bank_rdata_i[bank_sel_i];
    end
  end

  // ----------------------------------------------------------------------
  // Error counter
  // ----------------------------------------------------------------------
  assign err_rsp = rsp_valid_i & rsp_err_i;

  // Saturates at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_cnt_q <= '0;
    end else if (err_rsp && (err_cnt_q != 8'hff)) begin
      err_cnt_q <= err_cnt_q + 8'd1;
    end
  end

  assign err_count_o = err_cnt_q;

endmodule

`default_nettype wire

// File: source/harness_top.sv
// Harness top level joining reset control, address decode, SRAM banks and response return
`timescale 1ns/1ps
`default_nettype none

module harness_top #(
  parameter int unsigned NumBanks         = 4,
  parameter int unsigned BankWords        = 64,
  parameter int unsigned DebugDelayCycles = 16
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ndmreset_i,
  input  logic               debug_req_i,
  input  logic               debug_en_i,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::strb_t be_i,
  input  harness_pkg::data_t wdata_i,
  output logic               rsp_valid_o,
  output logic               rsp_err_o,
  output harness_pkg::data_t rdata_o,
  output logic [7:0]         err_count_o,
  output logic               debug_req_o,
  output logic               sys_rst_no
);

  localparam int unsigned IdxW = $clog2(BankWords);
  localparam int unsigned SelW = (NumBanks > 1) ? $clog2(NumBanks) : 1;

  // Request side shared by the banks
  logic [NumBanks-1:0] bank_req;
  logic [IdxW-1:0]     word_idx;
  logic                we;
  harness_pkg::strb_t  be;
  harness_pkg::data_t  wdata;

  // Response tag and bank read data
  logic                rsp_valid_q;
  logic                rsp_err_q;
  logic [SelW-1:0]     bank_sel_q;
  harness_pkg::data_t  bank_rdata [NumBanks];

  // ----------------------------------------------------------------------
  // Reset and debug gate
  // ----------------------------------------------------------------------
  reset_ctrl #(
    .DebugDelayCycles ( DebugDelayCycles )
  ) i_reset_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .sys_rst_no  ( sys_rst_no  ),
    .debug_req_o ( debug_req_o )
  );

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  bus_decoder #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords )
  ) i_bus_decoder (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_no  ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .bank_req_o  ( bank_req    ),
    .word_idx_o  ( word_idx    ),
    .we_o        ( we          ),
    .be_o        ( be          ),
    .wdata_o     ( wdata       ),
    .rsp_valid_o ( rsp_valid_q ),
    .rsp_err_o   ( rsp_err_q   ),
    .bank_sel_o  ( bank_sel_q  )
  );

  // ----------------------------------------------------------------------
  // SRAM banks
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    mem_bank #(
      .BankWords ( BankWords )
    ) i_mem_bank (
      .clk_i      ( clk_i         ),
      .req_i      ( bank_req[i]   ),
      .we_i       ( we            ),
      .word_idx_i ( word_idx      ),
      .be_i       ( be            ),
      .wdata_i    ( wdata         ),
      .rdata_o    ( bank_rdata[i] )
    );
  end

  // ----------------------------------------------------------------------
  // Response return
  // ----------------------------------------------------------------------
  resp_mux #(
    .NumBanks ( NumBanks )
  ) i_resp_mux (
    .clk_i        ( clk_i       ),
    .rst_ni       ( sys_rst_no  ),
    .rsp_valid_i  ( rsp_valid_q ),
    .rsp_err_i    ( rsp_err_q   ),
    .bank_sel_i   ( bank_sel_q  ),
    .bank_rdata_i ( bank_rdata  ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_err_o    ( rsp_err_o   ),
    .rdata_o      ( rdata_o     ),
    .err_count_o  ( err_count_o )
  );

endmodule

`default_nettype wire

// File: tests/harness_props.sv
// Response and reset timing assertions bound into the harness top level
`timescale 1ns/1ps
`default_nettype none

module harness_props (
  input logic               clk_i,
  input logic               sys_rst_ni,
  input logic               req_i,
  input logic               rsp_valid_i,
  input logic               rsp_err_i,
  input harness_pkg::data_t rdata_i
);

  // One response on the edge after each accepted request
  resp_after_req : assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
      (req_i && sys_rst_ni) |=> rsp_valid_i)
    else $error("rsp_valid_o did not follow an accepted request");

  // Error responses carry no data
  err_zero_data : assert property (@(posedge clk_i) rsp_err_i |-> (rdata_i == '0))
    else $error("rdata_o not zero on an error response");

  // Quiet while the system reset is held
  no_resp_in_reset : assert property (@(posedge clk_i) !sys_rst_ni |-> !rsp_valid_i)
    else $error("rsp_valid_o high while sys_rst_no is low");

endmodule

bind harness_top harness_props i_harness_props (
  .clk_i       ( clk_i       ),
  .sys_rst_ni  ( sys_rst_no  ),
  .req_i       ( req_i       ),
  .rsp_valid_i ( rsp_valid_o ),
  .rsp_err_i   ( rsp_err_o   ),
  .rdata_i     ( rdata_o     )
);

`default_nettype wire

// File: tests/harness_checker.sv
// Checker with a reference memory that predicts and compares every DUT response
`timescale 1ns/1ps
`default_nettype none

module harness_checker #(
  parameter int unsigned NumBanks         = 4,
  parameter int unsigned BankWords        = 64,
  parameter int unsigned DebugDelayCycles = 16
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ndmreset_i,
  input  logic               debug_req_i,
  input  logic               debug_en_i,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::strb_t be_i,
  input  harness_pkg::data_t wdata_i,
  input  logic               exp_err_i,
  input  logic               rsp_valid_i,
  input  logic               rsp_err_i,
  input  harness_pkg::data_t rdata_i,
  input  logic [7:0]         err_count_i,
  input  logic               dut_debug_req_i,
  input  logic               dut_sys_rst_ni,
  output int                 mismatch_o,
  output int                 fault_o,
  output int                 pending_o
);

  localparam int unsigned MapWords = NumBanks * BankWords;
  localparam harness_pkg::addr_t MapBytes =
      harness_pkg::addr_t'(MapWords * harness_pkg::DataBytes);

  harness_pkg::data_t ref_mem [MapWords];
  logic               known [MapWords];
  logic               exp_err_q [$];
  harness_pkg::data_t exp_data_q [$];
  logic               exp_chk_q [$];

  int unsigned        rel_edges;
  int unsigned        boot_edges;
  int unsigned        idx;
  logic [7:0]         exp_cnt;
  logic               sys_exp;
  logic               dbg_exp;
  logic               mapped;
  logic               cur_err;
  logic               cur_chk;
  harness_pkg::data_t cur_data;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    mismatch_o++;
  endtask

  task automatic report_fault(input string what);
    $display("ERROR at %0t: %s", $time, what);
    fault_o++;
  endtask

  task automatic push_expect(input logic err, input harness_pkg::data_t data,
                             input logic chk);
    exp_err_q.push_back(err);
    exp_data_q.push_back(data);
    exp_chk_q.push_back(chk);
  endtask

  initial begin
    for (int i = 0; i < MapWords; i++) begin
      known[i] = 1'b0;
    end
    rel_edges  = 0;
    boot_edges = 0;
    exp_cnt    = '0;
    mismatch_o = 0;
    fault_o    = 0;
    pending_o  = 0;
  end

  // ----------------------------------------------------------------------
  // Sampled on the falling edge, half a cycle clear of all driving
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    // Released two rising edges after both reset sources drop
    if (!rst_ni || ndmreset_i) begin
      rel_edges = 0;
    end
    sys_exp = (rel_edges >= 2);
    if (dut_sys_rst_ni !== sys_exp) begin
      report_mismatch("sys_rst_no", 64'(dut_sys_rst_ni), 64'(sys_exp));
    end
    if (!sys_exp) begin
      exp_cnt = '0;
    end
    if (err_count_i !== exp_cnt) begin
      report_mismatch("err_count_o", 64'(err_count_i), 64'(exp_cnt));
    end

    // Boot window counts only from power-on reset
    if (!rst_ni) begin
      boot_edges = 0;
    end
    dbg_exp = (boot_edges >= DebugDelayCycles) && debug_req_i && debug_en_i;
    if (dut_debug_req_i !== dbg_exp) begin
      report_mismatch("debug_req_o", 64'(dut_debug_req_i), 64'(dbg_exp));
    end

    // Response to the request of the previous cycle
    if (rsp_valid_i) begin
      if (exp_err_q.size() == 0) begin
        report_fault("response arrived without an accepted request");
      end else begin
        cur_err  = exp_err_q.pop_front();
        cur_data = exp_data_q.pop_front();
        cur_chk  = exp_chk_q.pop_front();
        if (rsp_err_i !== cur_err) begin
          report_mismatch("rsp_err_o", 64'(rsp_err_i), 64'(cur_err));
        end
        if (cur_chk && (rdata_i !== cur_data)) begin
          report_mismatch("rdata_o", rdata_i, cur_data);
        end
        if (cur_err && (exp_cnt != 8'hff)) begin
          exp_cnt = exp_cnt + 8'd1;
        end
      end
    end else if (exp_err_q.size() != 0) begin
      report_fault("no response one cycle after an accepted request");
      exp_err_q.delete();
      exp_data_q.delete();
      exp_chk_q.delete();
    end

    // New request, predicted against the reference memory
    if (req_i && sys_exp) begin
      mapped = (addr_i >= harness_pkg::MemBase) &&
               ((addr_i - harness_pkg::MemBase) < MapBytes);
      if (mapped == exp_err_i) begin
        report_fault("table error flag disagrees with the address map");
      end
      if (exp_err_i || !mapped) begin
        push_expect(exp_err_i, '0, 1'b1);
      end else begin
        idx = (addr_i - harness_pkg::MemBase) / harness_pkg::DataBytes;
        if (we_i) begin
          push_expect(1'b0, '0, 1'b1);
          for (int b = 0; b < harness_pkg::DataBytes; b++) begin
            if (be_i[b]) begin
              ref_mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
          if (be_i == '1) begin
            known[idx] = 1'b1;
          end
        end else begin
          push_expect(1'b0, ref_mem[idx], known[idx]);
        end
      end
    end

    // Count the coming rising edge
    if (rst_ni && !ndmreset_i) begin
      rel_edges++;
    end
    if (rst_ni) begin
      boot_edges++;
    end
    pending_o = exp_err_q.size();
  end

endmodule

`default_nettype wire

// File: tests/tb_harness_top.sv
// Testbench driving the harness memory subsystem from a table of requests
`timescale 1ns/1ps
`default_nettype none

module tb_harness_top;

  localparam int unsigned NumBanks         = 4;
  localparam int unsigned BankWords        = 64;
  localparam int unsigned DebugDelayCycles = 16;
  localparam int unsigned IdxW             = $clog2(BankWords);
  localparam int unsigned Margin           = 50;
  // Bank codes for addresses below the base and past the last bank
  localparam int          Below            = -1;
  localparam int          Past             = NumBanks;

  typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE, OP_NDM} op_e;

  logic               clk;
  logic               rst_n;
  logic               ndmreset;
  logic               debug_req;
  logic               debug_en;
  logic               req;
  logic               we;
  harness_pkg::addr_t addr;
  harness_pkg::strb_t be;
  harness_pkg::data_t wdata;
  logic               exp_err;
  logic               rsp_valid;
  logic               rsp_err;
  harness_pkg::data_t rdata;
  logic [7:0]         err_count;
  logic               debug_req_out;
  logic               sys_rst_n;
  int                 mismatches;
  int                 faults;
  int                 pending;
  logic [31:0]        lfsr;
  int unsigned        cycles;
  int unsigned        timeout_limit;

  // Stimulus table, one column per queue
  op_e                op_q [$];
  int                 bank_q [$];
  int                 word_q [$];
  harness_pkg::strb_t be_q [$];
  harness_pkg::data_t data_q [$];
  logic               rnd_q [$];
  logic               err_q [$];

  harness_top #(
    .NumBanks         ( NumBanks         ),
    .BankWords        ( BankWords        ),
    .DebugDelayCycles ( DebugDelayCycles )
  ) dut0 (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .ndmreset_i  ( ndmreset      ),
    .debug_req_i ( debug_req     ),
    .debug_en_i  ( debug_en      ),
    .req_i       ( req           ),
    .we_i        ( we            ),
    .addr_i      ( addr          ),
    .be_i        ( be            ),
    .wdata_i     ( wdata         ),
    .rsp_valid_o ( rsp_valid     ),
    .rsp_err_o   ( rsp_err       ),
    .rdata_o     ( rdata         ),
    .err_count_o ( err_count     ),
    .debug_req_o ( debug_req_out ),
    .sys_rst_no  ( sys_rst_n     )
  );

  harness_checker #(
    .NumBanks         ( NumBanks         ),
    .BankWords        ( BankWords        ),
    .DebugDelayCycles ( DebugDelayCycles )
  ) i_checker (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .ndmreset_i      ( ndmreset      ),
    .debug_req_i     ( debug_req     ),
    .debug_en_i      ( debug_en      ),
    .req_i           ( req           ),
    .we_i            ( we            ),
    .addr_i          ( addr          ),
    .be_i            ( be            ),
    .wdata_i         ( wdata         ),
    .exp_err_i       ( exp_err       ),
    .rsp_valid_i     ( rsp_valid     ),
    .rsp_err_i       ( rsp_err       ),
    .rdata_i         ( rdata         ),
    .err_count_i     ( err_count     ),
    .dut_debug_req_i ( debug_req_out ),
    .dut_sys_rst_ni  ( sys_rst_n     ),
    .mismatch_o      ( mismatches    ),
    .fault_o         ( faults        ),
    .pending_o       ( pending       )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [63:0] get_bits(input int n);
    logic        fb;
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic harness_pkg::addr_t word_addr(input int bank, input int word);
    harness_pkg::addr_t a;
    if (bank < 0) begin
      a = harness_pkg::MemBase - harness_pkg::addr_t'(harness_pkg::DataBytes * (word + 1));
    end else begin
      a = harness_pkg::MemBase +
          harness_pkg::addr_t'((bank * BankWords + word) * harness_pkg::DataBytes);
    end
    return a;
  endfunction

  // Word -1 and rnd set take the value from the LFSR
  task automatic add_entry(input op_e op, input int bank, input int word,
                           input harness_pkg::strb_t b, input harness_pkg::data_t d,
                           input logic rnd, input logic err);
    op_q.push_back(op);
    bank_q.push_back(bank);
    word_q.push_back(word);
    be_q.push_back(b);
    data_q.push_back(d);
    rnd_q.push_back(rnd);
    err_q.push_back(err);
  endtask

  task automatic build_table();
    // Full words first, then merging partial writes
    for (int b = 0; b < NumBanks; b++) begin
      add_entry(OP_WRITE, b, 3, 8'hff, '0, 1'b1, 1'b0);
      add_entry(OP_WRITE, b, 5, 8'hff, '0, 1'b1, 1'b0);
    end
    add_entry(OP_WRITE, 3, 63, 8'hff, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
    for (int b = 0; b < NumBanks; b++) begin
      add_entry(OP_WRITE, b, 3, 8'h0f, 64'h1111_2222_3333_4444, 1'b0, 1'b0);
    end
    for (int b = 0; b < NumBanks; b++) begin
      add_entry(OP_WRITE, b, 3, 8'ha0, '0, 1'b1, 1'b0);
    end
    for (int b = 0; b < NumBanks; b++) begin
      add_entry(OP_READ, b, 3, '0, '0, 1'b0, 1'b0);
      add_entry(OP_READ, b, 5, '0, '0, 1'b0, 1'b0);
    end
    // Back to back, alternating banks
    for (int i = 0; i < 8; i++) begin
      add_entry(OP_WRITE, i % NumBanks, 7, (i < 4) ? 8'hff : 8'h55, '0, 1'b1, 1'b0);
      add_entry(OP_READ, (i + 1) % NumBanks, (i < 4) ? 5 : 7, '0, '0, 1'b0, 1'b0);
    end
    add_entry(OP_WRITE, 1, -1, 8'hff, '0, 1'b1, 1'b0);
    add_entry(OP_WRITE, 2, -1, 8'hff, '0, 1'b1, 1'b0);
    for (int b = 0; b < NumBanks; b++) begin
      add_entry(OP_READ, b, 7, '0, '0, 1'b0, 1'b0);
    end
    // Unmapped, aliasing onto bank 3 word 63 and bank 0 word 3
    add_entry(OP_READ, Below, 0, '0, '0, 1'b0, 1'b1);
    add_entry(OP_WRITE, Below, 0, 8'hff, 64'hdead_beef_dead_beef, 1'b0, 1'b1);
    add_entry(OP_WRITE, Past, 3, 8'hff, 64'hfeed_face_feed_face, 1'b0, 1'b1);
    add_entry(OP_READ, Past, 0, '0, '0, 1'b0, 1'b1);
    add_entry(OP_READ, 3, 63, '0, '0, 1'b0, 1'b0);
    add_entry(OP_READ, 0, 3, '0, '0, 1'b0, 1'b0);
    // System reset request, then memory that survives it
    add_entry(OP_IDLE, 0, 0, '0, '0, 1'b0, 1'b0);
    add_entry(OP_NDM, 0, 3, '0, '0, 1'b0, 1'b0);
    add_entry(OP_READ, 0, 5, '0, '0, 1'b0, 1'b0);
    add_entry(OP_READ, Below, 1, '0, '0, 1'b0, 1'b1);
    add_entry(OP_READ, Past, 1, '0, '0, 1'b0, 1'b1);
    for (int b = 0; b < NumBanks; b++) begin
      add_entry(OP_READ, b, 5, '0, '0, 1'b0, 1'b0);
    end
    add_entry(OP_IDLE, 0, 0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic apply_entry(input int n);
    logic [63:0] bits;
    int          word;
    @(posedge clk);
    #2;
    bits      = get_bits(2);
    debug_req = bits[0];
    debug_en  = bits[1];
    word      = word_q[n];
    if (word < 0) begin
      bits = get_bits(IdxW);
      word = int'(bits);
    end
    if (rnd_q[n]) begin
      bits  = get_bits(64);
      wdata = bits;
    end else begin
      wdata = data_q[n];
    end
    req      = (op_q[n] != OP_IDLE);
    we       = (op_q[n] == OP_WRITE);
    ndmreset = (op_q[n] == OP_NDM);
    addr     = word_addr(bank_q[n], word);
    be       = be_q[n];
    exp_err  = err_q[n];
  endtask

  // ----------------------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (cycles > timeout_limit) begin
      $display("Timeout: run still going after %0d cycles", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    lfsr      = 32'h7dad;
    cycles    = 0;
    rst_n     = 1'b0;
    ndmreset  = 1'b0;
    debug_req = 1'b0;
    debug_en  = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    be        = '0;
    wdata     = '0;
    exp_err   = 1'b0;
    build_table();
    timeout_limit = op_q.size() + DebugDelayCycles + Margin;

    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Table starts once the system reset has come out
    while (sys_rst_n !== 1'b1) begin
      @(posedge clk);
      #2;
    end

    for (int n = 0; n < op_q.size(); n++) begin
      apply_entry(n);
    end
    @(posedge clk);
    #2;
    req = 1'b0;
    we  = 1'b0;

    // Drain the last responses
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    $display("Checks done: %0d mismatches, %0d other errors", mismatches, faults);
    if ((mismatches == 0) && (faults == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: harness_mem.f
source/harness_pkg.sv
source/reset_ctrl.sv
source/bus_decoder.sv
source/mem_bank.sv
source/resp_mux.sv
source/harness_top.sv
tests/harness_props.sv
tests/harness_checker.sv
tests/tb_harness_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the harness memory testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f harness_mem.f --top-module tb_harness_top -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
